/* verilog/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path width
`define CORE_XLEN 32

// Architectural register count, x0 included
`define CORE_NREGS 32

// Bits needed to name one register
`define CORE_REG_W 5

// Cycles the iterative multiplier stays busy
`define CORE_MUL_CYCLES 4

`endif

/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_MUL     = 3'b000;

    // funct7 values
    localparam logic [6:0] F7_SUB    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // Register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // Register-immediate format
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // One fetched word, read in whichever view the opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // Owner of the result held in EX2
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL
    } unit_e;

endpackage

`default_nettype wire

/* verilog/issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module issue_stage (
    input  wire logic                   clk,
    input  wire logic                   resetn,

    input  wire logic                   i_instr_valid,
    input  core_pkg::instr_u            i_instr,
    output logic                        o_instr_ready,

    output logic [`CORE_REG_W-1:0]      o_rs1_sel,
    output logic [`CORE_REG_W-1:0]      o_rs2_sel,
    input  wire logic [`CORE_XLEN-1:0]  i_rs1_data,
    input  wire logic [`CORE_XLEN-1:0]  i_rs2_data,

    input  wire logic                   i_ex2_pending,
    input  wire logic [`CORE_REG_W-1:0] i_ex2_rd,
    input  wire logic                   i_ex2_data_valid,
    input  wire logic [`CORE_XLEN-1:0]  i_ex2_data,
    input  wire logic                   i_ex2_ready,

    output logic                        o_ex1_valid,
    output logic [`CORE_REG_W-1:0]      o_ex1_rd,
    output core_pkg::unit_e             o_ex1_unit,
    output logic [`CORE_XLEN-1:0]       o_ex1_data,
    output logic [`CORE_XLEN-1:0]       o_ex1_data2,
    output logic                        o_ex1_value_valid
);

    import core_pkg::*;

    // Decoded fields
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [`CORE_REG_W-1:0] rs1;
    logic [`CORE_REG_W-1:0] rs2;
    logic [`CORE_REG_W-1:0] rd;
    logic                   is_op;
    logic                   is_imm;
    logic                   is_sub;
    logic                   is_mul;
    logic [`CORE_XLEN-1:0]  imm;

    // Operands after forwarding
    logic [`CORE_XLEN-1:0]  rs1_val;
    logic [`CORE_XLEN-1:0]  rs2_val;
    logic                   rs1_stall;
    logic                   rs2_stall;
    logic                   stall;
    logic                   accept;

    // ALU
    logic [`CORE_XLEN-1:0]  operand_b;
    logic [`CORE_XLEN-1:0]  sum;
    logic [`CORE_XLEN:0]    difference;
    logic                   lt_signed;
    logic                   lt_unsigned;
    logic [`CORE_XLEN-1:0]  alu_result;

    // EX1 register
    logic                   ex1_pending;
    logic [`CORE_REG_W-1:0] ex1_rd;
    unit_e                  ex1_unit;
    logic                   ex1_value_valid;
    logic [`CORE_XLEN-1:0]  ex1_data;
    logic [`CORE_XLEN-1:0]  ex1_data2;

    // Register fields sit at the same bits in both views
    assign opcode = i_instr.r.opcode;
    assign funct3 = i_instr.r.funct3;
    assign rs1    = i_instr.r.rs1;
    assign rs2    = i_instr.r.rs2;
    assign rd     = i_instr.r.rd;

    assign is_op  = (opcode == OPC_OP);
    assign is_imm = (opcode == OPC_OP_IMM);
    assign is_sub = is_op && (i_instr.r.funct7 == F7_SUB);
    assign is_mul = is_op && (i_instr.r.funct7 == F7_MULDIV) && (funct3 == F3_MUL);
    assign imm    = {{(`CORE_XLEN-12){i_instr.i.imm12[11]}}, i_instr.i.imm12};

    assign o_rs1_sel = rs1;
    assign o_rs2_sel = rs2;

    // EX1 is younger than EX2, so it wins
    always_comb begin
        rs1_val   = i_rs1_data;
        rs1_stall = 1'b0;
        if (rs1 != '0 && ex1_pending && ex1_rd == rs1) begin
            if (ex1_value_valid) begin
                rs1_val = ex1_data;
            end else begin
                rs1_stall = 1'b1;
            end
        end else if (rs1 != '0 && i_ex2_pending && i_ex2_rd == rs1) begin
            if (i_ex2_data_valid) begin
                rs1_val = i_ex2_data;
            end else begin
                rs1_stall = 1'b1;
            end
        end

        rs2_val   = i_rs2_data;
        rs2_stall = 1'b0;
        if (is_op && rs2 != '0 && ex1_pending && ex1_rd == rs2) begin
            if (ex1_value_valid) begin
                rs2_val = ex1_data;
            end else begin
                rs2_stall = 1'b1;
            end
        end else if (is_op && rs2 != '0 && i_ex2_pending && i_ex2_rd == rs2) begin
            if (i_ex2_data_valid) begin
                rs2_val = i_ex2_data;
            end else begin
                rs2_stall = 1'b1;
            end
        end
    end

    assign stall         = i_instr_valid && (rs1_stall || rs2_stall);
    assign o_instr_ready = !stall && (!ex1_pending || i_ex2_ready);
    assign accept        = i_instr_valid && o_instr_ready;

    assign operand_b  = is_imm ? imm : rs2_val;
    assign sum        = rs1_val + operand_b;
    assign difference = {1'b0, rs1_val} - {1'b0, operand_b};

    // Signs differ means the sign of a decides
    assign lt_signed   = (rs1_val[`CORE_XLEN-1] != operand_b[`CORE_XLEN-1]) ?
                         rs1_val[`CORE_XLEN-1] : difference[`CORE_XLEN-1];
    assign lt_unsigned = difference[`CORE_XLEN];

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_result = is_sub ? difference[`CORE_XLEN-1:0] : sum;
            F3_SLT:     alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            F3_SLTU:    alu_result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            default:    alu_result = sum;
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex1_pending     <= 1'b0;
            ex1_value_valid <= 1'b0;
            ex1_rd          <= '0;
            ex1_unit        <= UNIT_ALU;
        end else if (accept) begin
            ex1_pending     <= 1'b1;
            ex1_value_valid <= !is_mul;
            ex1_rd          <= rd;
            ex1_unit        <= is_mul ? UNIT_MUL : UNIT_ALU;
        end else if (ex1_pending && i_ex2_ready) begin
            ex1_pending     <= 1'b0;
            ex1_value_valid <= 1'b0;
        end
    end

    // MUL leaves both operands for EX2
    always_ff @(posedge clk) begin
        if (accept) begin
            ex1_data  <= is_mul ? rs1_val : alu_result;
            ex1_data2 <= rs2_val;
        end
    end

    assign o_ex1_valid       = ex1_pending;
    assign o_ex1_rd          = ex1_rd;
    assign o_ex1_unit        = ex1_unit;
    assign o_ex1_data        = ex1_data;
    assign o_ex1_data2       = ex1_data2;
    assign o_ex1_value_valid = ex1_value_valid;

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  wire logic                   clk,
    input  wire logic                   resetn,

    input  wire logic [`CORE_REG_W-1:0] i_rs1_sel,
    input  wire logic [`CORE_REG_W-1:0] i_rs2_sel,
    output logic [`CORE_XLEN-1:0]       o_rs1_data,
    output logic [`CORE_XLEN-1:0]       o_rs2_data,

    input  wire logic                   i_wb_en,
    input  wire logic [`CORE_REG_W-1:0] i_wb_rd,
    input  wire logic [`CORE_XLEN-1:0]  i_wb_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_en && i_wb_rd != '0) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // Write-through, the value being retired is not in EX2 any more
    always_comb begin
        if (i_rs1_sel == '0) begin
            o_rs1_data = '0;
        end else if (i_wb_en && i_wb_rd == i_rs1_sel) begin
            o_rs1_data = i_wb_data;
        end else begin
            o_rs1_data = regs[i_rs1_sel];
        end
    end

    always_comb begin
        if (i_rs2_sel == '0) begin
            o_rs2_data = '0;
        end else if (i_wb_en && i_wb_rd == i_rs2_sel) begin
            o_rs2_data = i_wb_data;
        end else begin
            o_rs2_data = regs[i_rs2_sel];
        end
    end

endmodule

`default_nettype wire

/* verilog/ex2_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module ex2_stage (
    input  wire logic                   clk,
    input  wire logic                   resetn,

    input  wire logic                   i_ex1_valid,
    input  wire logic [`CORE_REG_W-1:0] i_ex1_rd,
    input  core_pkg::unit_e             i_ex1_unit,
    input  wire logic [`CORE_XLEN-1:0]  i_ex1_data,
    input  wire logic [`CORE_XLEN-1:0]  i_ex1_data2,
    output logic                        o_ex2_ready,

    output logic                        o_ex2_pending,
    output logic [`CORE_REG_W-1:0]      o_ex2_rd,
    output logic                        o_ex2_data_valid,
    output logic [`CORE_XLEN-1:0]       o_ex2_data,

    output logic                        o_wb_en,
    output logic [`CORE_REG_W-1:0]      o_wb_rd,
    output logic [`CORE_XLEN-1:0]       o_wb_data
);

    import core_pkg::*;

    // Multiplier bits consumed per cycle
    localparam int CHUNK_W = `CORE_XLEN / `CORE_MUL_CYCLES;
    localparam int CNT_W   = $clog2(`CORE_MUL_CYCLES + 1);

    logic                   xfer;
    logic                   ex2_pending;
    logic [`CORE_REG_W-1:0] ex2_rd;
    unit_e                  ex2_unit;
    logic [`CORE_XLEN-1:0]  alu_data;

    logic [CNT_W-1:0]       mul_cnt;
    logic                   mul_done;
    logic [`CORE_XLEN-1:0]  mul_acc;
    logic [`CORE_XLEN-1:0]  mul_mcand;
    logic [`CORE_XLEN-1:0]  mul_mplier;
    logic [`CORE_XLEN-1:0]  partial_prod;

    logic                   data_valid;
    logic [`CORE_XLEN-1:0]  data;

    logic                   wb_en;
    logic [`CORE_REG_W-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]  wb_data;

    assign xfer        = i_ex1_valid && o_ex2_ready;
    assign o_ex2_ready = !ex2_pending || data_valid;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ex2_pending <= 1'b0;
            ex2_rd      <= '0;
            ex2_unit    <= UNIT_ALU;
        end else if (xfer) begin
            ex2_pending <= 1'b1;
            ex2_rd      <= i_ex1_rd;
            ex2_unit    <= i_ex1_unit;
        end else if (data_valid) begin
            ex2_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            alu_data <= i_ex1_data;
        end
    end

    // Shift-add, one chunk of the multiplier per cycle
    assign mul_done     = (mul_cnt == '0);
    assign partial_prod = mul_mcand *
                          {{(`CORE_XLEN-CHUNK_W){1'b0}}, mul_mplier[CHUNK_W-1:0]};

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            mul_cnt <= '0;
        end else if (xfer && i_ex1_unit == UNIT_MUL) begin
            mul_cnt <= CNT_W'(`CORE_MUL_CYCLES);
        end else if (!mul_done) begin
            mul_cnt <= mul_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer && i_ex1_unit == UNIT_MUL) begin
            mul_acc    <= '0;
            mul_mcand  <= i_ex1_data;
            mul_mplier <= i_ex1_data2;
        end else if (!mul_done) begin
            mul_acc    <= mul_acc + partial_prod;
            mul_mcand  <= mul_mcand << CHUNK_W;
            mul_mplier <= mul_mplier >> CHUNK_W;
        end
    end

    always_comb begin
        case (ex2_unit)
            UNIT_MUL: begin
                data_valid = ex2_pending && mul_done;
                data       = mul_acc;
            end
            default: begin
                data_valid = ex2_pending;
                data       = alu_data;
            end
        endcase
    end

    // Retire stage, one strobe per result
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= data_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (data_valid) begin
            wb_rd   <= ex2_rd;
            wb_data <= data;
        end
    end

    assign o_ex2_pending    = ex2_pending;
    assign o_ex2_rd         = ex2_rd;
    assign o_ex2_data_valid = data_valid;
    assign o_ex2_data       = data;
    assign o_wb_en          = wb_en;
    assign o_wb_rd          = wb_rd;
    assign o_wb_data        = wb_data;

endmodule

`default_nettype wire

/* verilog/exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module exec_core (
    input  wire logic              clk,
    input  wire logic              resetn,

    input  wire logic              i_instr_valid,
    input  core_pkg::instr_u       i_instr,
    output logic                   o_instr_ready,

    output logic                   o_wb_valid,
    output logic [`CORE_REG_W-1:0] o_wb_rd,
    output logic [`CORE_XLEN-1:0]  o_wb_data
);

    import core_pkg::*;

    // Register file reads
    logic [`CORE_REG_W-1:0] rs1_sel;
    logic [`CORE_REG_W-1:0] rs2_sel;
    logic [`CORE_XLEN-1:0]  rs1_data;
    logic [`CORE_XLEN-1:0]  rs2_data;

    // EX1 to EX2
    logic                   ex1_valid;
    logic [`CORE_REG_W-1:0] ex1_rd;
    unit_e                  ex1_unit;
    logic [`CORE_XLEN-1:0]  ex1_data;
    logic [`CORE_XLEN-1:0]  ex1_data2;
    logic                   ex1_value_valid;
    logic                   ex2_ready;

    // EX2 forwarding
    logic                   ex2_pending;
    logic [`CORE_REG_W-1:0] ex2_rd;
    logic                   ex2_data_valid;
    logic [`CORE_XLEN-1:0]  ex2_data;

    // Write-back
    logic                   wb_en;
    logic [`CORE_REG_W-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]  wb_data;

    issue_stage issue0 (
        .clk               (clk),
        .resetn            (resetn),
        .i_instr_valid     (i_instr_valid),
        .i_instr           (i_instr),
        .o_instr_ready     (o_instr_ready),
        .o_rs1_sel         (rs1_sel),
        .o_rs2_sel         (rs2_sel),
        .i_rs1_data        (rs1_data),
        .i_rs2_data        (rs2_data),
        .i_ex2_pending     (ex2_pending),
        .i_ex2_rd          (ex2_rd),
        .i_ex2_data_valid  (ex2_data_valid),
        .i_ex2_data        (ex2_data),
        .i_ex2_ready       (ex2_ready),
        .o_ex1_valid       (ex1_valid),
        .o_ex1_rd          (ex1_rd),
        .o_ex1_unit        (ex1_unit),
        .o_ex1_data        (ex1_data),
        .o_ex1_data2       (ex1_data2),
        .o_ex1_value_valid (ex1_value_valid)
    );

    reg_file rf0 (
        .clk        (clk),
        .resetn     (resetn),
        .i_rs1_sel  (rs1_sel),
        .i_rs2_sel  (rs2_sel),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wb_en    (wb_en),
        .i_wb_rd    (wb_rd),
        .i_wb_data  (wb_data)
    );

    ex2_stage ex2_0 (
        .clk              (clk),
        .resetn           (resetn),
        .i_ex1_valid      (ex1_valid),
        .i_ex1_rd         (ex1_rd),
        .i_ex1_unit       (ex1_unit),
        .i_ex1_data       (ex1_data),
        .i_ex1_data2      (ex1_data2),
        .o_ex2_ready      (ex2_ready),
        .o_ex2_pending    (ex2_pending),
        .o_ex2_rd         (ex2_rd),
        .o_ex2_data_valid (ex2_data_valid),
        .o_ex2_data       (ex2_data),
        .o_wb_en          (wb_en),
        .o_wb_rd          (wb_rd),
        .o_wb_data        (wb_data)
    );

    assign o_wb_valid = wb_en;
    assign o_wb_rd    = wb_rd;
    assign o_wb_data  = wb_data;

endmodule

`default_nettype wire

/* sim/exec_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module exec_core_asserts (
    input wire logic                   clk,
    input wire logic                   resetn,
    input wire logic                   i_instr_valid,
    input wire logic [31:0]            i_instr,
    input wire logic                   i_instr_ready,
    input wire logic [`CORE_REG_W-1:0] i_rs1_sel,
    input wire logic [`CORE_REG_W-1:0] i_rs2_sel,
    input wire logic                   i_ex1_valid,
    input wire logic                   i_ex1_value_valid,
    input wire logic [`CORE_REG_W-1:0] i_ex1_rd,
    input wire logic                   i_ex2_pending,
    input wire logic                   i_ex2_data_valid,
    input wire logic [`CORE_REG_W-1:0] i_ex2_rd,
    input wire logic                   i_wb_valid,
    input wire logic [`CORE_REG_W-1:0] i_wb_rd
);

    int   assert_failures = 0;
    logic uses_rs2;
    logic rs1_blocked;
    logic rs2_blocked;

    // Only register-register ops read rs2
    assign uses_rs2 = (i_instr[6:0] == 7'b0110011);

    // Youngest matching producer decides
    always_comb begin
        rs1_blocked = 1'b0;
        if (i_rs1_sel != '0 && i_ex1_valid && i_ex1_rd == i_rs1_sel) begin
            rs1_blocked = !i_ex1_value_valid;
        end else if (i_rs1_sel != '0 && i_ex2_pending && i_ex2_rd == i_rs1_sel) begin
            rs1_blocked = !i_ex2_data_valid;
        end

        rs2_blocked = 1'b0;
        if (uses_rs2 && i_rs2_sel != '0 && i_ex1_valid && i_ex1_rd == i_rs2_sel) begin
            rs2_blocked = !i_ex1_value_valid;
        end else if (uses_rs2 && i_rs2_sel != '0 && i_ex2_pending && i_ex2_rd == i_rs2_sel) begin
            rs2_blocked = !i_ex2_data_valid;
        end
    end

    wb_quiet_in_reset: assert property (@(posedge clk) !resetn |-> !i_wb_valid)
        else begin
            $error("write-back strobe seen while reset is asserted");
            assert_failures++;
        end

    no_accept_on_mul_hazard: assert property (@(posedge clk) disable iff (!resetn)
        (i_instr_valid && i_instr_ready) |-> !(rs1_blocked || rs2_blocked))
        else begin
            $error("instruction accepted while a source waits on a MUL result");
            assert_failures++;
        end

    // A new destination may only appear together with a strobe
    wb_rd_held: assert property (@(posedge clk) disable iff (!resetn)
        !$stable(i_wb_rd) |-> i_wb_valid)
        else begin
            $error("o_wb_rd changed without a write-back strobe");
            assert_failures++;
        end

endmodule

bind exec_core exec_core_asserts asserts0 (
    .clk               (clk),
    .resetn            (resetn),
    .i_instr_valid     (i_instr_valid),
    .i_instr           (i_instr),
    .i_instr_ready     (o_instr_ready),
    .i_rs1_sel         (rs1_sel),
    .i_rs2_sel         (rs2_sel),
    .i_ex1_valid       (ex1_valid),
    .i_ex1_value_valid (ex1_value_valid),
    .i_ex1_rd          (ex1_rd),
    .i_ex2_pending     (ex2_pending),
    .i_ex2_data_valid  (ex2_data_valid),
    .i_ex2_rd          (ex2_rd),
    .i_wb_valid        (o_wb_valid),
    .i_wb_rd           (o_wb_rd)
);

`default_nettype wire

/* sim/exec_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_config.svh"

module exec_core_tb;

    localparam int CLK_HALF = 10;

    // {funct7, funct3} of the register-register ops
    localparam logic [9:0] K_ADD  = {7'h00, 3'h0};
    localparam logic [9:0] K_SUB  = {7'h20, 3'h0};
    localparam logic [9:0] K_SLT  = {7'h00, 3'h2};
    localparam logic [9:0] K_SLTU = {7'h00, 3'h3};
    localparam logic [9:0] K_MUL  = {7'h01, 3'h0};

    logic                   clk;
    logic                   resetn;
    logic                   instr_valid;
    logic [31:0]            instr;
    logic                   instr_ready;
    logic                   wb_valid;
    logic [`CORE_REG_W-1:0] wb_rd;
    logic [`CORE_XLEN-1:0]  wb_data;

    // Test table, instructions of all entries in one flat list
    string                  test_name[$];
    int                     test_first[$];
    int                     test_count[$];
    bit                     test_stalls[$];
    logic [31:0]            instr_list[$];
    logic [4:0]             exp_rd_list[$];
    logic [31:0]            exp_val_list[$];

    logic [31:0]            model_regs [32];
    logic [31:0]            rng_state;
    int                     error_count;
    int                     tests_failed;
    int                     tests_run;
    bit                     table_built;
    bit                     stall_seen;

    exec_core dut0 (
        .clk           (clk),
        .resetn        (resetn),
        .i_instr_valid (instr_valid),
        .i_instr       (instr),
        .o_instr_ready (instr_ready),
        .o_wb_valid    (wb_valid),
        .o_wb_rd       (wb_rd),
        .o_wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [11:0] next_imm();
        rng_state = xorshift32(rng_state);
        return rng_state[11:0];
    endfunction

    function automatic logic [31:0] encode_r(input logic [9:0] kind, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
        return {kind[9:3], rs2, rs1, kind[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // Architectural model, x0 stays zero
    task automatic model_execute(input logic [31:0] ins, output logic [4:0] rd,
                                 output logic [31:0] value);
        logic [31:0] a;
        logic [31:0] b;
        rd = ins[11:7];
        a  = model_regs[ins[19:15]];
        b  = model_regs[ins[24:20]];
        if (ins[6:0] == 7'b0010011) begin
            value = a + {{20{ins[31]}}, ins[31:20]};
        end else begin
            case ({ins[31:25], ins[14:12]})
                K_SUB:   value = a - b;
                K_SLT:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_SLTU:  value = (a < b) ? 32'd1 : 32'd0;
                K_MUL:   value = a * b;
                default: value = a + b;
            endcase
        end
        if (rd != 5'd0) begin
            model_regs[rd] = value;
        end
    endtask

    task automatic start_test(input string name, input bit stalls);
        test_name.push_back(name);
        test_first.push_back(instr_list.size());
        test_count.push_back(0);
        test_stalls.push_back(stalls);
    endtask

    task automatic push_instr(input logic [31:0] ins);
        logic [4:0]  rd;
        logic [31:0] value;
        model_execute(ins, rd, value);
        instr_list.push_back(ins);
        exp_rd_list.push_back(rd);
        exp_val_list.push_back(value);
        test_count[test_count.size() - 1] = test_count[test_count.size() - 1] + 1;
    endtask

    task automatic build_table();
        start_test("addi_imm", 1'b0);
        push_instr(encode_addi(5'd1, 5'd0, 12'h07b));
        push_instr(encode_addi(5'd2, 5'd0, 12'hf85));
        push_instr(encode_addi(5'd3, 5'd0, next_imm()));
        push_instr(encode_addi(5'd4, 5'd0, next_imm()));
        push_instr(encode_addi(5'd3, 5'd3, 12'h7ff));

        start_test("add_sub", 1'b0);
        push_instr(encode_r(K_ADD, 5'd5, 5'd3, 5'd4));
        push_instr(encode_r(K_SUB, 5'd6, 5'd3, 5'd4));
        push_instr(encode_r(K_SUB, 5'd7, 5'd2, 5'd1));
        push_instr(encode_r(K_ADD, 5'd8, 5'd5, 5'd6));

        // -7 against +5
        start_test("slt_sltu", 1'b0);
        push_instr(encode_addi(5'd9, 5'd0, 12'hff9));
        push_instr(encode_addi(5'd10, 5'd0, 12'h005));
        push_instr(encode_r(K_SLT, 5'd11, 5'd9, 5'd10));
        push_instr(encode_r(K_SLTU, 5'd12, 5'd9, 5'd10));
        push_instr(encode_r(K_SLT, 5'd13, 5'd10, 5'd9));
        push_instr(encode_r(K_SLTU, 5'd14, 5'd10, 5'd9));
        push_instr(encode_r(K_SLT, 5'd15, 5'd9, 5'd9));

        start_test("fwd_chain", 1'b0);
        push_instr(encode_addi(5'd16, 5'd0, next_imm()));
        push_instr(encode_r(K_ADD, 5'd17, 5'd16, 5'd16));
        push_instr(encode_r(K_ADD, 5'd18, 5'd17, 5'd16));
        push_instr(encode_r(K_SUB, 5'd19, 5'd18, 5'd17));
        push_instr(encode_addi(5'd19, 5'd19, next_imm()));
        push_instr(encode_r(K_ADD, 5'd20, 5'd19, 5'd18));

        start_test("mul_dep", 1'b1);
        push_instr(encode_addi(5'd21, 5'd0, next_imm()));
        push_instr(encode_addi(5'd22, 5'd0, next_imm()));
        push_instr(encode_r(K_MUL, 5'd23, 5'd21, 5'd22));
        push_instr(encode_r(K_ADD, 5'd24, 5'd23, 5'd21));
        push_instr(encode_r(K_MUL, 5'd25, 5'd23, 5'd23));
        push_instr(encode_r(K_SUB, 5'd26, 5'd25, 5'd24));
        push_instr(encode_r(K_MUL, 5'd27, 5'd26, 5'd5));

        start_test("x0_write", 1'b0);
        push_instr(encode_addi(5'd0, 5'd0, 12'h07b));
        push_instr(encode_r(K_ADD, 5'd0, 5'd1, 5'd2));
        push_instr(encode_r(K_ADD, 5'd28, 5'd0, 5'd1));
        push_instr(encode_r(K_SLTU, 5'd29, 5'd0, 5'd1));
        push_instr(encode_r(K_MUL, 5'd0, 5'd1, 5'd1));
        push_instr(encode_r(K_SUB, 5'd30, 5'd0, 5'd2));
    endtask

    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", label, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_idle_after_reset();
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_value("reset_idle o_instr_ready", 32'd1, 32'(instr_ready));
            check_value("reset_idle o_wb_valid", 32'd0, 32'(wb_valid));
        end
    endtask

    // Holds each instruction until the edge that accepts it
    task automatic drive_test(input int first, input int count);
        bit accepted;
        for (int k = 0; k < count; k++) begin
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= instr_list[first + k];
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = instr_ready;
                if (!instr_ready) begin
                    stall_seen = 1'b1;
                end
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic collect_test(input string name, input int first, input int count);
        int got;
        got = 0;
        while (got < count) begin
            @(negedge clk);
            if (wb_valid) begin
                check_value($sformatf("%s #%0d rd", name, got),
                            32'(exp_rd_list[first + got]), 32'(wb_rd));
                check_value($sformatf("%s #%0d data", name, got),
                            exp_val_list[first + got], wb_data);
                got++;
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    initial begin
        int limit;
        wait (table_built);
        limit = instr_list.size() * (`CORE_MUL_CYCLES + 4) + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int errors_before;
        resetn       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        rng_state    = 32'h360d_334b;
        error_count  = 0;
        tests_failed = 0;
        tests_run    = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_table();
        table_built = 1'b1;

        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        errors_before = error_count;
        check_idle_after_reset();
        report_test("reset_idle", errors_before);

        for (int t = 0; t < test_name.size(); t++) begin
            errors_before = error_count;
            stall_seen    = 1'b0;
            fork
                drive_test(test_first[t], test_count[t]);
                collect_test(test_name[t], test_first[t], test_count[t]);
            join
            if (test_stalls[t] && !stall_seen) begin
                $display("%s: o_instr_ready never dropped behind a pending MUL", test_name[t]);
                error_count++;
            end
            report_test(test_name[t], errors_before);
        end

        if (dut0.asserts0.assert_failures != 0) begin
            $display("Assertions in dut0 failed %0d times", dut0.asserts0.assert_failures);
            error_count = error_count + dut0.asserts0.assert_failures;
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/issue_stage.sv
verilog/reg_file.sv
verilog/ex2_stage.sv
verilog/exec_core.sv
sim/exec_core_asserts.sv
sim/exec_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module exec_core_tb -o exec_core_sim

status=0
output=$(./obj_dir/exec_core_sim +verilator+error+limit+1000 2>&1) || status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    exit "$status"
fi

if echo "$output" | grep -q "^TESTS PASSED$"; then
    exit 0
fi
exit 1
